/* core_settings.svh */
// core settings
// widths and counts shared by the integer core and its testbench

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// datapath
////////////////////////////////////////////////////////////

`define XLEN 32 // integer register and datapath width

`define NREGS 32 // integer registers, x0 included

////////////////////////////////////////////////////////////
// divider
////////////////////////////////////////////////////////////

// one quotient bit per iteration, so this is also the divide latency
`define DIVSTEPS `XLEN

`endif

/* isaPkg.sv */
// isa package
// rv32 instruction formats, the two-view instruction word and the
// opcode / funct encodings of the kept integer subset

package isaPkg;

  ////////////////////////////////////////////////////////////
  // major opcodes
  ////////////////////////////////////////////////////////////

  typedef enum logic [6:0] {
    opReg = 7'b0110011, // register-register ops, M extension too
    opImm = 7'b0010011  // register-immediate ops
  } opcodeT;

  ////////////////////////////////////////////////////////////
  // formats
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode; // raw bits, unknown opcodes must survive
  } rTypeT;

  typedef struct packed {
    logic [11:0] imm12; // sign-extended by the core
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iTypeT;

  // same 32 bits, read as R or I depending on opcode
  typedef union packed {
    rTypeT r;
    iTypeT i;
  } instrWordT;

  ////////////////////////////////////////////////////////////
  // funct7 spaces
  ////////////////////////////////////////////////////////////

  localparam logic [6:0] f7Base   = 7'b0000000; // base integer ops
  localparam logic [6:0] f7Alt    = 7'b0100000; // sub / sra space
  localparam logic [6:0] f7MulDiv = 7'b0000001; // M extension

  // funct3 in the base space, shared by reg and imm forms
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Sll    = 3'b001;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3Srl    = 3'b101;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;

  // funct3 in the mulDiv space, unsigned divide only
  localparam logic [2:0] f3Divu   = 3'b101;
  localparam logic [2:0] f3Remu   = 3'b111;

endpackage

/* corePkg.sv */
// core package
// controller states, alu operation codes and the register index type

`include "core_settings.svh"

package corePkg;

  // index into the integer register file
  typedef logic [$clog2(`NREGS)-1:0] regIdxT;

  ////////////////////////////////////////////////////////////
  // alu
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt, // signed compare, 0 or 1
    aluSll,
    aluSrl
  } aluOpT;

  ////////////////////////////////////////////////////////////
  // controller FSM
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    sIdle,       // waiting on instrReq
    sAck,        // instrAck high until instrReq drops
    sExec,       // decode, alu result or divider start
    sDivWait,    // divider busy
    sRetire,     // retireReq high, result frozen
    sRetireDone  // waiting on retireAck to fall
  } ctrlStateT;

endpackage

/* regFile.sv */
// integer register file
// two combinational read ports, one write port on the clock edge,
// x0 hard-wired to zero

`include "core_settings.svh"

module regFile (
  input  logic               clk,
  input  logic               arstN,
  input  corePkg::regIdxT    rs1,
  input  corePkg::regIdxT    rs2,
  input  corePkg::regIdxT    rd,
  input  logic               we,
  input  logic [`XLEN-1:0]   wd,
  output logic [`XLEN-1:0]   rd1,
  output logic [`XLEN-1:0]   rd2
);

  logic [`XLEN-1:0] regs [1:`NREGS-1]; // no storage for x0

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < `NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin // x0 writes dropped
      regs[rd] <= wd;
    end
  end

  // x0 reads as zero
  assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* alu.sv */
// integer alu
// single-cycle combinational unit for the kept R and I operations

`include "core_settings.svh"

module alu (
  input  corePkg::aluOpT     op,
  input  logic [`XLEN-1:0]   a,
  input  logic [`XLEN-1:0]   b,
  output logic [`XLEN-1:0]   y
);

  localparam int ShW = $clog2(`XLEN);

  logic [ShW-1:0] shamt; // low bits of b only
  logic           lessThan;

  assign shamt    = b[ShW-1:0];
  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      corePkg::aluAdd: y = a + b;
      corePkg::aluSub: y = a - b;
      corePkg::aluAnd: y = a & b;
      corePkg::aluOr:  y = a | b;
      corePkg::aluXor: y = a ^ b;
      corePkg::aluSlt: y = {{(`XLEN-1){1'b0}}, lessThan};
      corePkg::aluSll: y = a << shamt;
      corePkg::aluSrl: y = a >> shamt; // logical, zero fill
      default:         y = '0;
    endcase
  end

endmodule

/* divider.sv */
// unsigned divider
// restoring shift-subtract, one quotient bit per cycle, fixed latency
// of DIVSTEPS cycles from start to busy falling

`include "core_settings.svh"

module divider (
  input  logic               clk,
  input  logic               arstN,
  input  logic               start,     // one-cycle pulse
  input  logic [`XLEN-1:0]   dividend,
  input  logic [`XLEN-1:0]   divisor,
  output logic               busy,
  output logic [`XLEN-1:0]   quotient,  // valid once busy falls
  output logic [`XLEN-1:0]   remainder
);

  localparam int CntW = $clog2(`DIVSTEPS);

  logic [CntW-1:0]   stepCnt;   // iteration counter
  logic [`XLEN-1:0]  remReg;    // partial remainder
  logic [`XLEN-1:0]  quoReg;    // dividend shifts out, quotient shifts in
  logic [`XLEN-1:0]  dsrReg;    // divisor held for the whole run
  logic [`XLEN:0]    remShift;  // remainder with next dividend bit
  logic [`XLEN+1:0]  trial;     // extra msb is the borrow
  logic              lastStep;

  ////////////////////////////////////////////////////////////
  // one iteration
  ////////////////////////////////////////////////////////////

  assign remShift = {remReg, quoReg[`XLEN-1]};
  assign trial    = {1'b0, remShift} - {2'b00, dsrReg};
  assign lastStep = (stepCnt == CntW'(`DIVSTEPS - 1));

  // control: busy and the step count
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busy    <= 1'b0;
      stepCnt <= '0;
    end else if (start) begin
      busy    <= 1'b1;
      stepCnt <= '0;
    end else if (busy) begin
      stepCnt <= stepCnt + 1'b1;
      if (lastStep) begin
        busy <= 1'b0; // last quotient bit lands on this edge
      end
    end
  end

  // datapath
  // zero divisor never borrows, so quotient fills with ones and the
  // remainder collects the dividend bit by bit
  always_ff @(posedge clk) begin
    if (start) begin
      remReg <= '0;
      quoReg <= dividend;
      dsrReg <= divisor;
    end else if (busy) begin
      remReg <= trial[`XLEN+1] ? remShift[`XLEN-1:0] : trial[`XLEN-1:0]; // restore on borrow
      quoReg <= {quoReg[`XLEN-2:0], ~trial[`XLEN+1]};
    end
  end

  assign quotient  = quoReg;
  assign remainder = remReg;

endmodule

/* coreCtrl.sv */
// core controller
// runs the instruction and retire handshakes, decodes the captured
// word through its R and I views and sequences alu, divider and
// register writeback, one instruction at a time

`include "core_settings.svh"

module coreCtrl (
  input  logic               clk,
  input  logic               arstN,
  // instruction handshake
  input  logic               instrReq,
  input  isaPkg::instrWordT  instr,
  output logic               instrAck,
  // retire handshake
  output logic               retireReq,
  input  logic               retireAck,
  output corePkg::regIdxT    retireRd,
  output logic [`XLEN-1:0]   retireValue,
  output logic               retireIllegal,
  // register file
  output corePkg::regIdxT    rs1,
  output corePkg::regIdxT    rs2,
  output corePkg::regIdxT    rd,
  output logic               regWe,
  output logic [`XLEN-1:0]   regWd,
  input  logic [`XLEN-1:0]   rd1,
  input  logic [`XLEN-1:0]   rd2,
  // alu
  output corePkg::aluOpT     aluOp,
  output logic [`XLEN-1:0]   aluB,
  input  logic [`XLEN-1:0]   aluY,
  // divider
  output logic               divStart,
  input  logic               divBusy,
  input  logic [`XLEN-1:0]   quotient,
  input  logic [`XLEN-1:0]   remainder
);

  corePkg::ctrlStateT state, stateNext;

  isaPkg::instrWordT  instrReg;    // held from capture to next capture
  logic               useImm;      // operand b from imm12
  logic               isDiv;       // divu or remu
  logic               isRem;       // remu picks the remainder
  logic               illegal;
  logic               enterRetire; // the one cycle before sRetire
  logic [`XLEN-1:0]   wbValue;
  logic [`XLEN-1:0]   immExt;
  logic [`XLEN-1:0]   resultReg;
  logic               illegalReg;

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    aluOp   = corePkg::aluAdd;
    useImm  = 1'b0;
    isDiv   = 1'b0;
    isRem   = 1'b0;
    illegal = 1'b0;
    case (instrReg.r.opcode)
      isaPkg::opReg: begin
        case (instrReg.r.funct7)
          isaPkg::f7Base: begin
            case (instrReg.r.funct3)
              isaPkg::f3AddSub: aluOp = corePkg::aluAdd;
              isaPkg::f3Sll:    aluOp = corePkg::aluSll;
              isaPkg::f3Slt:    aluOp = corePkg::aluSlt;
              isaPkg::f3Xor:    aluOp = corePkg::aluXor;
              isaPkg::f3Srl:    aluOp = corePkg::aluSrl;
              isaPkg::f3Or:     aluOp = corePkg::aluOr;
              isaPkg::f3And:    aluOp = corePkg::aluAnd;
              default:          illegal = 1'b1; // sltu
            endcase
          end
          isaPkg::f7Alt: begin
            if (instrReg.r.funct3 == isaPkg::f3AddSub) aluOp = corePkg::aluSub;
            else                                       illegal = 1'b1; // sra
          end
          isaPkg::f7MulDiv: begin
            case (instrReg.r.funct3)
              isaPkg::f3Divu: isDiv = 1'b1;
              isaPkg::f3Remu: begin
                isDiv = 1'b1;
                isRem = 1'b1;
              end
              default:        illegal = 1'b1; // mul, signed div
            endcase
          end
          default: illegal = 1'b1;
        endcase
      end
      isaPkg::opImm: begin
        useImm = 1'b1;
        case (instrReg.i.funct3)
          isaPkg::f3AddSub: aluOp = corePkg::aluAdd;
          isaPkg::f3Xor:    aluOp = corePkg::aluXor;
          isaPkg::f3Or:     aluOp = corePkg::aluOr;
          isaPkg::f3And:    aluOp = corePkg::aluAnd;
          default:          illegal = 1'b1; // slti, shifts by imm
        endcase
      end
      default: illegal = 1'b1; // anything outside the kept opcodes
    endcase
  end

  assign immExt = {{(`XLEN-12){instrReg.i.imm12[11]}}, instrReg.i.imm12};
  assign aluB   = useImm ? immExt : rd2;

  // register indices straight from the held word
  assign rs1 = instrReg.r.rs1;
  assign rs2 = instrReg.r.rs2;
  assign rd  = instrReg.r.rd;

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  always_comb begin
    stateNext = state;
    case (state)
      corePkg::sIdle:       if (instrReq)   stateNext = corePkg::sAck;
      corePkg::sAck:        if (!instrReq)  stateNext = corePkg::sExec;
      corePkg::sExec:       stateNext = isDiv ? corePkg::sDivWait : corePkg::sRetire;
      corePkg::sDivWait:    if (!divBusy)   stateNext = corePkg::sRetire;
      corePkg::sRetire:     if (retireAck)  stateNext = corePkg::sRetireDone;
      corePkg::sRetireDone: if (!retireAck) stateNext = corePkg::sIdle;
      default:              stateNext = corePkg::sIdle;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) state <= corePkg::sIdle;
    else        state <= stateNext;
  end

  // handshake outputs follow the registered state
  assign instrAck  = (state == corePkg::sAck);
  assign retireReq = (state == corePkg::sRetire);

  // start pulses once; divider busy is already high in sDivWait
  assign divStart = (state == corePkg::sExec) && isDiv;

  ////////////////////////////////////////////////////////////
  // writeback and retire payload
  ////////////////////////////////////////////////////////////

  assign enterRetire = ((state == corePkg::sExec) && !isDiv) ||
                       ((state == corePkg::sDivWait) && !divBusy);

  assign wbValue = isDiv ? (isRem ? remainder : quotient) : aluY;
  assign regWe   = enterRetire && !illegal; // single write per instruction
  assign regWd   = wbValue;

  always_ff @(posedge clk) begin
    if ((state == corePkg::sIdle) && instrReq) begin
      instrReg <= instr; // stable while instrReq is high
    end
    if (enterRetire) begin
      resultReg  <= illegal ? '0 : wbValue; // reported even for rd = x0
      illegalReg <= illegal;
    end
  end

  // frozen through back-pressure, nothing reloads until the next capture
  assign retireRd      = instrReg.r.rd;
  assign retireValue   = resultReg;
  assign retireIllegal = illegalReg;

endmodule

/* coreTop.sv */
// integer core top level
// controller, register file, alu and divider behind the instruction
// and retire handshakes

`include "core_settings.svh"

module coreTop (
  input  logic               clk,
  input  logic               arstN,
  // instruction in
  input  logic               instrReq,
  input  isaPkg::instrWordT  instr,
  output logic               instrAck,
  // retirement out
  output logic               retireReq,
  input  logic               retireAck,
  output corePkg::regIdxT    retireRd,
  output logic [`XLEN-1:0]   retireValue,
  output logic               retireIllegal
);

  corePkg::regIdxT   rs1, rs2, rdIdx;
  logic              regWe;
  logic [`XLEN-1:0]  regWd;
  logic [`XLEN-1:0]  rd1, rd2;   // source operands
  corePkg::aluOpT    aluOp;
  logic [`XLEN-1:0]  aluB, aluY;
  logic              divStart, divBusy;
  logic [`XLEN-1:0]  quotient, remainder;

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  coreCtrl ctrl (
    .clk, .arstN,
    .instrReq, .instr, .instrAck,
    .retireReq, .retireAck, .retireRd, .retireValue, .retireIllegal,
    .rs1, .rs2, .rd(rdIdx), .regWe, .regWd, .rd1, .rd2,
    .aluOp, .aluB, .aluY,
    .divStart, .divBusy, .quotient, .remainder
  );

  ////////////////////////////////////////////////////////////
  // execution
  ////////////////////////////////////////////////////////////

  regFile rf (
    .clk, .arstN,
    .rs1, .rs2, .rd(rdIdx),
    .we(regWe), .wd(regWd),
    .rd1, .rd2
  );

  // operand a is always rs1
  alu alu0 (
    .op(aluOp), .a(rd1), .b(aluB), .y(aluY)
  );

  divider div (
    .clk, .arstN,
    .start(divStart),
    .dividend(rd1), .divisor(rd2), // sampled on the start cycle
    .busy(divBusy),
    .quotient, .remainder
  );

endmodule

/* tbCore.sv */
// integer core testbench
// directed tests through the instruction and retire handshakes,
// checked against a register file model built from the rv32 rules

`include "core_settings.svh"

module tbCore;

  localparam int MaxAckDelay    = 8;                 // longest retireAck stall
  localparam int NumInstr       = 110;               // upper bound on issued instructions
  localparam int HsTimeout      = `DIVSTEPS + 20;    // per handshake edge, in cycles
  localparam int WatchdogCycles = 2 * NumInstr * (`DIVSTEPS + 20 + MaxAckDelay);
  localparam int ShW            = $clog2(`XLEN);

  logic              clk;
  logic              arstN;
  logic              instrReq;
  logic              instrAck;
  isaPkg::instrWordT instr;
  logic              retireReq;
  logic              retireAck;
  corePkg::regIdxT   retireRd;
  logic [`XLEN-1:0]  retireValue;
  logic              retireIllegal;

  logic [`XLEN-1:0]  model [`NREGS]; // expected register contents
  int                errors;
  int                timeouts;

  coreTop dut (
    .clk, .arstN,
    .instrReq, .instr, .instrAck,
    .retireReq, .retireAck, .retireRd, .retireValue, .retireIllegal
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // encoder and reference model
  ////////////////////////////////////////////////////////////

  function automatic isaPkg::instrWordT encR(input logic [6:0] f7, input logic [2:0] f3,
      input corePkg::regIdxT rd, input corePkg::regIdxT rs1, input corePkg::regIdxT rs2);
    isaPkg::instrWordT w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = isaPkg::opReg;
    return w;
  endfunction

  function automatic isaPkg::instrWordT encI(input logic [2:0] f3, input corePkg::regIdxT rd,
      input corePkg::regIdxT rs1, input logic [11:0] imm);
    isaPkg::instrWordT w;
    w.i.imm12  = imm;
    w.i.rs1    = rs1;
    w.i.funct3 = f3;
    w.i.rd     = rd;
    w.i.opcode = isaPkg::opImm;
    return w;
  endfunction

  function automatic logic [`XLEN-1:0] signExt(input logic [11:0] imm);
    logic signed [`XLEN-1:0] wide;
    wide = $signed(imm); // signed assignment widens with the sign bit
    return wide;
  endfunction

  // rv32i / divu / remu semantics
  function automatic logic [`XLEN-1:0] refResult(input logic [6:0] f7, input logic [2:0] f3,
      input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
    logic [`XLEN-1:0] y;
    y = '0;
    if (f7 == isaPkg::f7MulDiv) begin
      if (b == '0) y = (f3 == isaPkg::f3Divu) ? '1 : a; // divide by zero rule
      else         y = (f3 == isaPkg::f3Divu) ? a / b : a % b;
    end else begin
      case (f3)
        isaPkg::f3AddSub: y = (f7 == isaPkg::f7Alt) ? a - b : a + b;
        isaPkg::f3Sll:    y = a << b[ShW-1:0];
        isaPkg::f3Slt:    y = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
        isaPkg::f3Xor:    y = a ^ b;
        isaPkg::f3Srl:    y = a >> b[ShW-1:0];
        isaPkg::f3Or:     y = a | b;
        default:          y = a & b;
      endcase
    end
    return y;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic checkValue(input string name, input logic [`XLEN-1:0] exp,
      input logic [`XLEN-1:0] act);
    if (act !== exp) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic checkIdx(input string name, input corePkg::regIdxT exp,
      input corePkg::regIdxT act);
    if (act !== exp) begin
      $display("error %s: expected rd %0d, actual rd %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s: expected illegal %b, actual illegal %b", name, exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // handshake drivers
  ////////////////////////////////////////////////////////////

  // waits at falling edges for instrAck or retireReq to reach a level
  task automatic waitHandshake(input bit onRetire, input logic level, input string what);
    int n;
    n = 0;
    while (((onRetire ? retireReq : instrAck) !== level) && (n < HsTimeout)) begin
      @(negedge clk);
      n++;
    end
    if ((onRetire ? retireReq : instrAck) !== level) begin
      $display("timeout: %s did not happen within %0d cycles", what, HsTimeout);
      timeouts++;
    end
  endtask

  task automatic startSend(input isaPkg::instrWordT w);
    @(negedge clk);
    instr    = w;
    instrReq = 1'b1;
  endtask

  task automatic finishSend();
    waitHandshake(1'b0, 1'b1, "instrAck rising");
    instrReq = 1'b0;
    waitHandshake(1'b0, 1'b0, "instrAck falling");
  endtask

  // holds retireAck off for delay cycles, outputs must not move meanwhile
  task automatic collectRetire(input string name, input int delay, output corePkg::regIdxT rdA,
      output logic [`XLEN-1:0] valA, output logic illA);
    waitHandshake(1'b1, 1'b1, "retireReq rising");
    rdA  = retireRd;
    valA = retireValue;
    illA = retireIllegal;
    repeat (delay) begin
      @(negedge clk);
      checkIdx({name, " held"}, rdA, retireRd);
      checkValue({name, " held"}, valA, retireValue);
      checkFlag({name, " held"}, illA, retireIllegal);
      if ((retireReq !== 1'b1) || (instrAck !== 1'b0)) begin
        $display("error %s: retireReq dropped or instrAck rose before retireAck", name);
        errors++;
      end
    end
    retireAck = 1'b1;
    waitHandshake(1'b1, 1'b0, "retireReq falling");
    retireAck = 1'b0;
  endtask

  task automatic checkRetire(input string name, input isaPkg::instrWordT w,
      input logic [`XLEN-1:0] expVal, input logic expIll, input corePkg::regIdxT rdA,
      input logic [`XLEN-1:0] valA, input logic illA);
    checkIdx(name, w.r.rd, rdA);
    checkValue(name, expVal, valA);
    checkFlag(name, expIll, illA);
    if (!expIll && (w.r.rd != '0)) model[w.r.rd] = expVal; // x0 never written
  endtask

  task automatic issue(input string name, input isaPkg::instrWordT w,
      input logic [`XLEN-1:0] expVal, input logic expIll, input int delay);
    corePkg::regIdxT  rdA;
    logic [`XLEN-1:0] valA;
    logic             illA;
    startSend(w);
    finishSend();
    collectRetire(name, delay, rdA, valA, illA);
    checkRetire(name, w, expVal, expIll, rdA, valA, illA);
  endtask

  task automatic issueR(input string name, input logic [6:0] f7, input logic [2:0] f3,
      input corePkg::regIdxT rd, input corePkg::regIdxT rs1, input corePkg::regIdxT rs2,
      input int delay);
    issue(name, encR(f7, f3, rd, rs1, rs2), refResult(f7, f3, model[rs1], model[rs2]),
          1'b0, delay);
  endtask

  task automatic issueI(input string name, input logic [2:0] f3, input corePkg::regIdxT rd,
      input corePkg::regIdxT rs1, input logic [11:0] imm, input int delay);
    issue(name, encI(f3, rd, rs1, imm), refResult(isaPkg::f7Base, f3, model[rs1], signExt(imm)),
          1'b0, delay);
  endtask

  // full 32-bit constant in 10 + 11 + 11 bit pieces, x30 holds 11, x31 scratch
  task automatic loadReg(input corePkg::regIdxT idx, input logic [`XLEN-1:0] value);
    issueI("load hi", isaPkg::f3AddSub, idx, 5'd0, {2'b00, value[31:22]}, 0);
    issueR("load shift", isaPkg::f7Base, isaPkg::f3Sll, idx, idx, 5'd30, 0);
    issueI("load mid", isaPkg::f3AddSub, 5'd31, 5'd0, {1'b0, value[21:11]}, 0);
    issueR("load merge", isaPkg::f7Base, isaPkg::f3Or, idx, idx, 5'd31, 0);
    issueR("load shift", isaPkg::f7Base, isaPkg::f3Sll, idx, idx, 5'd30, 0);
    issueI("load lo", isaPkg::f3AddSub, 5'd31, 5'd0, {1'b0, value[10:0]}, 0);
    issueR("load merge", isaPkg::f7Base, isaPkg::f3Or, idx, idx, 5'd31, 0);
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic testImmediate();
    corePkg::regIdxT rd;
    corePkg::regIdxT rs1;
    logic [11:0]     imm;
    logic [2:0]      f3;
    // nonzero sources so and, or and xor give different results
    for (int i = 1; i <= 4; i++) begin
      issueI("immediate setup", isaPkg::f3AddSub, corePkg::regIdxT'(i), 5'd0, 12'($urandom), 0);
    end
    for (int i = 0; i < 8; i++) begin
      rd  = corePkg::regIdxT'($urandom % 29 + 1); // keep off scratch regs
      rs1 = corePkg::regIdxT'($urandom % 4 + 1);
      imm = 12'($urandom);
      case (i % 4)
        0:       f3 = isaPkg::f3AddSub;
        1:       f3 = isaPkg::f3And;
        2:       f3 = isaPkg::f3Or;
        default: f3 = isaPkg::f3Xor;
      endcase
      issueI($sformatf("immediate %0d", i), f3, rd, rs1, imm, int'($urandom % 3));
    end
  endtask

  task automatic testRegister();
    logic [6:0] f7;
    logic [2:0] f3;
    for (int i = 1; i <= 4; i++) begin
      issueI("register setup", isaPkg::f3AddSub, corePkg::regIdxT'(i), 5'd0, 12'($urandom), 0);
    end
    for (int k = 0; k < 8; k++) begin
      f7 = isaPkg::f7Base;
      case (k)
        0: f3 = isaPkg::f3AddSub;
        1: begin
          f3 = isaPkg::f3AddSub;
          f7 = isaPkg::f7Alt; // sub
        end
        2: f3 = isaPkg::f3And;
        3: f3 = isaPkg::f3Or;
        4: f3 = isaPkg::f3Xor;
        5: f3 = isaPkg::f3Slt;
        6: f3 = isaPkg::f3Sll;
        default: f3 = isaPkg::f3Srl;
      endcase
      issueR($sformatf("register op %0d", k), f7, f3, corePkg::regIdxT'(5 + k),
             corePkg::regIdxT'(1 + k % 4), corePkg::regIdxT'(1 + (k + 1) % 4), 1);
    end
  endtask

  task automatic testZeroReg();
    issueI("x0 destination", isaPkg::f3AddSub, 5'd0, 5'd1, 12'h07b, 1); // retires, no write
    issueR("x0 both sources", isaPkg::f7Base, isaPkg::f3AddSub, 5'd6, 5'd0, 5'd0, 1);
    issueR("x0 one source", isaPkg::f7Base, isaPkg::f3Or, 5'd6, 5'd0, 5'd2, 1);
  endtask

  task automatic testDivide();
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    issueI("divide shift setup", isaPkg::f3AddSub, 5'd30, 5'd0, 12'd11, 0);
    for (int i = 0; i < 4; i++) begin
      a = $urandom;
      b = (i == 3) ? '0 : ($urandom >> ($urandom % 32)); // last round divides by zero
      loadReg(5'd10, a);
      loadReg(5'd11, b);
      issueR($sformatf("divu %0d", i), isaPkg::f7MulDiv, isaPkg::f3Divu, 5'd12, 5'd10, 5'd11, 1);
      issueR($sformatf("remu %0d", i), isaPkg::f7MulDiv, isaPkg::f3Remu, 5'd13, 5'd10, 5'd11, 1);
    end
  endtask

  task automatic testIllegal();
    isaPkg::instrWordT w;
    issueI("illegal setup", isaPkg::f3AddSub, 5'd7, 5'd0, 12'($urandom), 0);
    w          = $urandom;
    w.r.opcode = 7'b0000011; // load opcode, not in the kept set
    w.r.rd     = 5'd7;
    issue("illegal opcode", w, '0, 1'b1, 1);
    issueI("illegal readback", isaPkg::f3AddSub, 5'd8, 5'd7, 12'h000, 1);
    issue("illegal funct7", encR(7'b0000010, isaPkg::f3AddSub, 5'd7, 5'd1, 5'd2), '0, 1'b1, 1);
    issueI("illegal readback 2", isaPkg::f3AddSub, 5'd8, 5'd7, 12'h000, 1);
  endtask

  // second instruction waits on instrReq while the first is stalled in retire
  task automatic testBackPressure();
    isaPkg::instrWordT first;
    isaPkg::instrWordT second;
    logic [`XLEN-1:0]  expFirst;
    corePkg::regIdxT   rdA;
    logic [`XLEN-1:0]  valA;
    logic              illA;
    int                delay;
    for (int i = 0; i < 3; i++) begin
      delay    = 1 + int'($urandom % MaxAckDelay);
      first    = encR(isaPkg::f7Base, isaPkg::f3Xor, 5'd14, 5'd1, 5'd2);
      second   = encR(isaPkg::f7MulDiv, isaPkg::f3Remu, 5'd15, 5'd14, 5'd3); // uses first's rd
      expFirst = refResult(isaPkg::f7Base, isaPkg::f3Xor, model[1], model[2]);
      startSend(first);
      finishSend();
      startSend(second);
      collectRetire($sformatf("stalled %0d", i), delay, rdA, valA, illA);
      checkRetire($sformatf("stalled %0d", i), first, expFirst, 1'b0, rdA, valA, illA);
      finishSend();
      collectRetire($sformatf("resumed %0d", i), 0, rdA, valA, illA);
      checkRetire($sformatf("resumed %0d", i), second,
                  refResult(isaPkg::f7MulDiv, isaPkg::f3Remu, model[14], model[3]),
                  1'b0, rdA, valA, illA);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    arstN     = 1'b0;
    instrReq  = 1'b0;
    instr     = '0;
    retireAck = 1'b0;
    errors    = 0;
    timeouts  = 0;
    for (int i = 0; i < `NREGS; i++) begin
      model[i] = '0; // matches the register file after reset
    end
    void'($urandom(32'h69bb7d55));
    repeat (10) @(negedge clk);
    arstN = 1'b1;
    testImmediate();
    testRegister();
    testZeroReg();
    testDivide();
    testIllegal();
    testBackPressure();
    $display("checks done: %0d value errors, %0d handshake timeouts", errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", WatchdogCycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+.
isaPkg.sv
corePkg.sv
regFile.sv
alu.sv
divider.sv
coreCtrl.sv
coreTop.sv
tbCore.sv

/* run.sh */
#!/bin/sh
# compile and run the integer core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tbCore -o simCore
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/simCore > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
exit 0
